//--- verilog.f
+incdir+bench
design/pitaya_pkg.sv
design/sys_bus_if.sv
design/sys_bus_decoder.sv
design/housekeeping_regs.sv
design/adc_frontend.sv
design/dac_formatter.sv
design/pitaya_top.sv
bench/tb_pitaya_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run tb_pitaya_top with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  --top-module tb_pitaya_top \
  -Mdir "$BUILD_DIR" \
  -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/Vtb_pitaya_top" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG_FILE"; then
  exit 0
else
  echo "Pass message not found in $LOG_FILE"
  exit 1
fi

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Response kinds seen at the master
typedef enum logic [1:0] {RESP_NONE, RESP_ACK, RESP_ERR, RESP_BOTH} resp_kind_t;

////////////////////////////////////////////////////////////
// Reference model

function automatic resp_kind_t resp_of(input logic ack, input logic err);
  case ({ack, err})
    2'b10:   return RESP_ACK;
    2'b01:   return RESP_ERR;
    2'b11:   return RESP_BOTH;
    default: return RESP_NONE;
  endcase
endfunction

// Negative slope, top code bit selects the half
function automatic sample_t model_sample(input adc_raw_t raw);
  int low;
  int val;
  low = int'(raw[14:2]);    // Low two raw bits ignored
  if (raw[15])
    val = -1 - low;         // Negative half
  else
    val = 8191 - low;
  return sample_t'(val);
endfunction

// Inverse of the ADC rule
function automatic dac_code_t model_dac_code(input sample_t w);
  int val;
  int code;
  val = int'(w);
  if (val < 0)
    code = 8192 + (-1 - val);
  else
    code = 8191 - val;
  return dac_code_t'(code);
endfunction

// Only selected byte lanes take new data
function automatic bus_data_t model_merge(input bus_data_t old_val, input bus_data_t new_val,
                                          input bus_sel_t sel);
  bus_data_t res;
  res = old_val;
  for (int b = 0; b < 4; b++)
  begin
    if (sel[b])
      res[8*b +: 8] = new_val[8*b +: 8];
  end
  return res;
endfunction

function automatic bus_data_t word_of_sample(input sample_t s);
  return {{18{s[13]}}, s};  // Sign extended readback
endfunction

////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_code(input string name, input dac_code_t exp, input dac_code_t act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_bank(input string name, input exp_bank_t exp, input exp_bank_t act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_led(input string name, input led_t exp, input led_t act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_resp(input string name, input resp_kind_t exp, input resp_kind_t act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
  end
endtask

`endif

//--- bench/tb_pitaya_top.sv
`timescale 1ns/1ps

module tb_pitaya_top;
  import pitaya_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int RESP_TIMEOUT = 20;   // Cycles per bus wait

  logic      adc_clk;
  logic      reset_i;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  bus_addr_t wb_adr;
  bus_data_t wb_wdata;
  bus_sel_t  wb_sel;
  bus_data_t wb_rdata;
  logic      wb_ack;
  logic      wb_err;
  adc_raw_t  adc_a_raw;
  adc_raw_t  adc_b_raw;
  exp_bank_t exp_in;
  exp_bank_t exp_out;
  exp_bank_t exp_dir;
  led_t      led;
  dac_code_t dac_a_code;
  dac_code_t dac_b_code;
  logic      dac_rst;

  int          err_cnt;
  int          check_cnt;
  logic [15:0] lfsr;      // Fibonacci, taps 16 14 13 11

  // Model state of the register block
  led_t      m_led;
  exp_bank_t m_dir;
  exp_bank_t m_out;
  sample_t   m_dac_a;
  sample_t   m_dac_b;

  `include "tb_checks.svh"

  pitaya_top uut (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_wdata),
    .wb_sel_i    (wb_sel),
    .wb_dat_o    (wb_rdata),
    .wb_ack_o    (wb_ack),
    .wb_err_o    (wb_err),
    .adc_dat_a_i (adc_a_raw),
    .adc_dat_b_i (adc_b_raw),
    .exp_in_i    (exp_in),
    .exp_out_o   (exp_out),
    .exp_dir_o   (exp_dir),
    .led_o       (led),
    .dac_dat_a_o (dac_a_code),
    .dac_dat_b_o (dac_b_code),
    .dac_rst_o   (dac_rst)
  );

  initial adc_clk = 1'b0;
  always #10 adc_clk = ~adc_clk;  // 50 MHz

  // One LFSR step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] res;
    logic        fb;
    res = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      res  = {res[30:0], fb};
    end
    return res;
  endfunction

  function automatic bus_addr_t region_addr(input region_t r, input hk_offset_t ofs);
    return {9'd0, r, ofs};
  endfunction

  ////////////////////////////////////////////////////////////
  // Wishbone classic master

  task automatic bus_access(input logic we, input bus_addr_t adr, input bus_data_t wdata,
                            input bus_sel_t sel, output bus_data_t rdata,
                            output resp_kind_t resp);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    resp   = RESP_NONE;
    @(posedge adc_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_wdata <= wdata;
    wb_sel   <= sel;
    while (!seen && waited < RESP_TIMEOUT)
    begin
      @(negedge adc_clk);  // Outputs settled here
      waited++;
      if (wb_ack || wb_err)
      begin
        seen  = 1'b1;
        rdata = wb_rdata;
        resp  = resp_of(wb_ack, wb_err);
      end
    end
    if (!seen)
    begin
      err_cnt++;
      $display("No response from the DUT within %0d cycles at address %h", RESP_TIMEOUT, adr);
      $display("TEST RESULT: FAIL");
      $finish;
    end
    else
    begin
      // First negedge falls in the request cycle, second in the response cycle
      if (waited != 2)
      begin
        err_cnt++;
        $display("Response at address %h came %0d cycles after the request", adr, waited);
      end
      @(posedge adc_clk);
      wb_cyc <= 1'b0;  // Drop after the response
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge adc_clk);
      if (wb_ack || wb_err)
      begin
        err_cnt++;
        $display("Request at address %h was answered twice", adr);
      end
    end
  endtask

  task automatic write_reg(input string name, input hk_offset_t ofs, input bus_data_t data,
                           input bus_sel_t sel);
    bus_data_t  rd;
    resp_kind_t resp;
    bus_access(1'b1, region_addr(REGION_HK, ofs), data, sel, rd, resp);
    check_resp(name, RESP_ACK, resp);
  endtask

  task automatic read_reg(input string name, input hk_offset_t ofs, output bus_data_t rd);
    resp_kind_t resp;
    bus_access(1'b0, region_addr(REGION_HK, ofs), '0, 4'hf, rd, resp);
    check_resp(name, RESP_ACK, resp);
  endtask

  // Random word under random or full lanes into one DAC word
  task automatic write_dac_word(input logic chan_b, input bus_sel_t sel);
    bus_data_t data;
    data = rand_bits(32);
    if (chan_b)
    begin
      m_dac_b = sample_t'(model_merge(word_of_sample(m_dac_b), data, sel));
      write_reg("DAC_B write", HK_OFS_DAC_B, data, sel);
    end
    else
    begin
      m_dac_a = sample_t'(model_merge(word_of_sample(m_dac_a), data, sel));
      write_reg("DAC_A write", HK_OFS_DAC_A, data, sel);
    end
  endtask

  // Pins against the model, codes two cycles past the write
  task automatic check_outputs(input string name);
    check_led({name, " led_o"}, m_led, led);
    check_bank({name, " exp_dir_o"}, m_dir, exp_dir);
    check_bank({name, " exp_out_o"}, m_out, exp_out);
    check_code({name, " dac_dat_a_o"}, model_dac_code(m_dac_a), dac_a_code);
    check_code({name, " dac_dat_b_o"}, model_dac_code(m_dac_b), dac_b_code);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    bus_data_t   data;
    bus_data_t   rd;
    bus_data_t   tmp;
    bus_sel_t    sel;
    hk_offset_t  ofs;
    region_t     reg_n;
    resp_kind_t  resp;
    adc_raw_t    raw_a;
    adc_raw_t    raw_b;
    exp_bank_t   ein;
    int          tgt;

    err_cnt   = 0;
    check_cnt = 0;
    lfsr      = 16'd31315;
    m_led     = '0;
    m_dir     = '0;
    m_out     = '0;
    m_dac_a   = '0;
    m_dac_b   = '0;
    reset_i   <= 1'b1;
    wb_cyc    <= 1'b0;
    wb_stb    <= 1'b0;
    wb_we     <= 1'b0;
    wb_adr    <= '0;
    wb_wdata  <= '0;
    wb_sel    <= '0;
    adc_a_raw <= '0;
    adc_b_raw <= '0;
    exp_in    <= '0;

    repeat (RESET_CYCLES) @(posedge adc_clk);
    reset_i <= 1'b0;

    // Reset state, codes still cleared while dac_rst_o is high
    @(negedge adc_clk);
    check_led("reset led_o", '0, led);
    check_bank("reset exp_dir_o", '0, exp_dir);
    check_code("reset dac_dat_a_o", '0, dac_a_code);
    check_code("reset dac_dat_b_o", '0, dac_b_code);
    check_resp("reset response", RESP_NONE, resp_of(wb_ack, wb_err));
    check_cnt++;
    if (dac_rst !== 1'b1)
    begin
      err_cnt++;
      $display("dac_rst_o was low right after reset release");
    end
    @(negedge adc_clk);
    check_cnt++;
    if (dac_rst !== 1'b0)
    begin
      err_cnt++;
      $display("dac_rst_o still high one cycle after reset release");
    end

    // ID and unused regions
    read_reg("ID read", HK_OFS_ID, rd);
    check_data("ID value", HK_ID, rd);
    read_reg("LOOP read", HK_OFS_LOOP, rd);
    check_data("LOOP after reset", '0, rd);
    for (int i = 0; i < 16; i++)
    begin
      reg_n = region_t'(rand_bits(3));
      if (reg_n == REGION_HK)
        reg_n = 3'd7;
      ofs  = hk_offset_t'(rand_bits(20));
      data = rand_bits(32);
      tmp  = rand_bits(1);
      bus_access(tmp[0], region_addr(reg_n, ofs), data, 4'hf, rd, resp);
      check_resp("unused region response", RESP_ACK, resp);
      check_data("unused region data", '0, rd);
    end

    // Byte select on LED and expansion registers
    for (int i = 0; i < 24; i++)
    begin
      tgt  = int'(rand_bits(2)) % 3;
      data = rand_bits(32);
      sel  = bus_sel_t'(rand_bits(4));
      case (tgt)
        0:
        begin
          ofs   = HK_OFS_LED;
          m_led = led_t'(model_merge({24'd0, m_led}, data, sel));
          tmp   = {24'd0, m_led};
        end
        1:
        begin
          ofs   = HK_OFS_EXP_DIR;
          m_dir = exp_bank_t'(model_merge({24'd0, m_dir}, data, sel));
          tmp   = {24'd0, m_dir};
        end
        default:
        begin
          ofs   = HK_OFS_EXP_OUT;
          m_out = exp_bank_t'(model_merge({24'd0, m_out}, data, sel));
          tmp   = {24'd0, m_out};
        end
      endcase
      write_reg("byte select write", ofs, data, sel);
      check_outputs("byte select");
      read_reg("byte select read", ofs, rd);
      check_data("byte select readback", tmp, rd);
    end

    // Offsets past ADC_B
    for (int i = 0; i < 6; i++)
    begin
      tmp  = rand_bits(8);
      ofs  = HK_OFS_ADC_B + 20'h4 + {10'd0, tmp[7:0], 2'b00};
      data = rand_bits(32);
      tmp  = rand_bits(1);
      bus_access(tmp[0], region_addr(REGION_HK, ofs), data, 4'hf, rd, resp);
      check_resp("unmapped response", RESP_ERR, resp);
      check_outputs("unmapped");
    end

    // ADC conversion, loopback off
    write_reg("LOOP clear", HK_OFS_LOOP, '0, 4'hf);
    for (int i = 0; i < 12; i++)
    begin
      raw_a = adc_raw_t'(rand_bits(16));
      raw_b = adc_raw_t'(rand_bits(16));
      ein   = exp_bank_t'(rand_bits(8));
      @(posedge adc_clk);
      adc_a_raw <= raw_a;
      adc_b_raw <= raw_b;
      exp_in    <= ein;
      repeat (2) @(posedge adc_clk);  // Input register plus margin
      read_reg("ADC_A read", HK_OFS_ADC_A, rd);
      check_sample("ADC_A sample", model_sample(raw_a), sample_t'(rd[13:0]));
      read_reg("ADC_B read", HK_OFS_ADC_B, rd);
      check_sample("ADC_B sample", model_sample(raw_b), sample_t'(rd[13:0]));
      read_reg("EXP_IN read", HK_OFS_EXP_IN, rd);
      check_bank("EXP_IN value", ein, rd[7:0]);
    end

    // DAC words to converter codes
    for (int i = 0; i < 12; i++)
    begin
      write_dac_word(1'b0, bus_sel_t'(rand_bits(4)));
      write_dac_word(1'b1, bus_sel_t'(rand_bits(4)));
      check_outputs("DAC path");
      read_reg("DAC_A read", HK_OFS_DAC_A, rd);
      check_data("DAC_A readback", word_of_sample(m_dac_a), rd);
    end

    // Loopback, ADC reads follow the stored DAC words
    write_reg("LOOP set", HK_OFS_LOOP, 32'h1, 4'h1);
    read_reg("LOOP read", HK_OFS_LOOP, rd);
    check_data("LOOP value", 32'h1, rd);
    for (int i = 0; i < 8; i++)
    begin
      write_dac_word(1'b0, 4'hf);
      write_dac_word(1'b1, 4'hf);
      read_reg("loop ADC_A read", HK_OFS_ADC_A, rd);
      check_sample("loop ADC_A sample", m_dac_a, sample_t'(rd[13:0]));
      read_reg("loop ADC_B read", HK_OFS_ADC_B, rd);
      check_sample("loop ADC_B sample", m_dac_b, sample_t'(rd[13:0]));
    end
    write_reg("LOOP clear", HK_OFS_LOOP, '0, 4'hf);

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- design/pitaya_top.sv
`timescale 1ns/1ps

module pitaya_top (
  input  logic                  adc_clk,
  input  logic                  reset_i,

  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  pitaya_pkg::bus_addr_t wb_adr_i,
  input  pitaya_pkg::bus_data_t wb_dat_i,
  input  pitaya_pkg::bus_sel_t  wb_sel_i,
  output pitaya_pkg::bus_data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,

  // ADC
  input  pitaya_pkg::adc_raw_t  adc_dat_a_i,  // Channel 1
  input  pitaya_pkg::adc_raw_t  adc_dat_b_i,  // Channel 2

  // Expansion bank, no pad buffers here
  input  pitaya_pkg::exp_bank_t exp_in_i,
  output pitaya_pkg::exp_bank_t exp_out_o,
  output pitaya_pkg::exp_bank_t exp_dir_o,

  output pitaya_pkg::led_t      led_o,

  // DAC
  output pitaya_pkg::dac_code_t dac_dat_a_o,
  output pitaya_pkg::dac_code_t dac_dat_b_o,
  output logic                  dac_rst_o
);
  import pitaya_pkg::*;

  logic    digital_loop;  // Loopback switch
  sample_t adc_a;         // Converted or looped samples
  sample_t adc_b;
  sample_t dac_a;         // Stored DAC words
  sample_t dac_b;

  sys_bus_if hk_bus ();

  ////////////////////////////////////////////////////////////
  // Bus decoder, region 0 to housekeeping

  sys_bus_decoder i_decoder (
    .adc_clk  (adc_clk),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .hk_bus   (hk_bus.host)
  );

  housekeeping_regs i_hk (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .adc_a_i   (adc_a),
    .adc_b_i   (adc_b),
    .exp_in_i  (exp_in_i),
    .loop_o    (digital_loop),
    .led_o     (led_o),
    .exp_dir_o (exp_dir_o),
    .exp_out_o (exp_out_o),
    .dac_a_o   (dac_a),
    .dac_b_o   (dac_b),
    .bus       (hk_bus.device)
  );

  ////////////////////////////////////////////////////////////
  // Converter data paths

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (digital_loop),
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  dac_formatter i_dac (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o)
  );

endmodule

//--- design/dac_formatter.sv
`timescale 1ns/1ps

module dac_formatter (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  pitaya_pkg::sample_t   dac_a_i,
  input  pitaya_pkg::sample_t   dac_b_i,
  output pitaya_pkg::dac_code_t dac_dat_a_o,
  output pitaya_pkg::dac_code_t dac_dat_b_o,
  output logic                  dac_rst_o
);
  import pitaya_pkg::*;

  dac_code_t code_a_q;
  dac_code_t code_b_q;
  logic      rst_q;     // Converter reset, one cycle behind reset_i

  ////////////////////////////////////////////////////////////
  // Converter reset

  always_ff @(posedge adc_clk)
  begin
    rst_q <= reset_i;
  end

  ////////////////////////////////////////////////////////////
  // Output registers, signed to offset form

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      code_a_q <= '0;  // Quiet while the converter is held
      code_b_q <= '0;
    end
    else
    begin
      code_a_q <= flip_low_bits(dac_a_i);
      code_b_q <= flip_low_bits(dac_b_i);
    end
  end

  assign dac_dat_a_o = code_a_q;
  assign dac_dat_b_o = code_b_q;
  assign dac_rst_o   = rst_q;

  // Codes stay cleared for as long as the converter sees reset
  a_codes_zero_in_rst: assert property (@(posedge adc_clk)
    dac_rst_o |-> (dac_dat_a_o == '0 && dac_dat_b_o == '0))
    else $error("DAC code not zero during converter reset");

endmodule

//--- design/adc_frontend.sv
`timescale 1ns/1ps

module adc_frontend (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  input  pitaya_pkg::adc_raw_t adc_dat_a_i,
  input  pitaya_pkg::adc_raw_t adc_dat_b_i,
  input  logic                 loop_i,
  input  pitaya_pkg::sample_t  dac_a_i,
  input  pitaya_pkg::sample_t  dac_b_i,
  output pitaya_pkg::sample_t  adc_a_o,
  output pitaya_pkg::sample_t  adc_b_o
);
  import pitaya_pkg::*;

  logic [13:0] raw_a_q;  // Converter code, offset form
  logic [13:0] raw_b_q;
  sample_t     conv_a;
  sample_t     conv_b;

  ////////////////////////////////////////////////////////////
  // Input registers

  // Upper 14 bits only
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      raw_a_q <= CODE_ZERO;  // Reads as a zero sample
      raw_b_q <= CODE_ZERO;
    end
    else
    begin
      raw_a_q <= adc_dat_a_i[15:ADC_LSB_UNUSED];
      raw_b_q <= adc_dat_b_i[15:ADC_LSB_UNUSED];
    end
  end

  ////////////////////////////////////////////////////////////
  // Conversion and loopback

  // Negative slope converter
  assign conv_a = sample_t'(flip_low_bits(raw_a_q));
  assign conv_b = sample_t'(flip_low_bits(raw_b_q));

  // Stored DAC words, no extra delay
  assign adc_a_o = loop_i ? dac_a_i : conv_a;
  assign adc_b_o = loop_i ? dac_b_i : conv_b;

endmodule

//--- design/housekeeping_regs.sv
`timescale 1ns/1ps

module housekeeping_regs (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  pitaya_pkg::sample_t   adc_a_i,
  input  pitaya_pkg::sample_t   adc_b_i,
  input  pitaya_pkg::exp_bank_t exp_in_i,
  output logic                  loop_o,
  output pitaya_pkg::led_t      led_o,
  output pitaya_pkg::exp_bank_t exp_dir_o,
  output pitaya_pkg::exp_bank_t exp_out_o,
  output pitaya_pkg::sample_t   dac_a_o,
  output pitaya_pkg::sample_t   dac_b_o,
  sys_bus_if.device             bus
);
  import pitaya_pkg::*;

  logic      loop_q;
  led_t      led_q;
  exp_bank_t exp_dir_q;
  exp_bank_t exp_out_q;
  sample_t   dac_a_q;
  sample_t   dac_b_q;

  logic      accept;   // New request, not one already answered
  logic      hit;      // Offset is in the map
  bus_data_t rd_word;  // Current contents at the offset
  bus_data_t wr_word;  // rd_word with selected bytes replaced

  // Byte lane merge under sel
  function automatic bus_data_t merge_bytes(input bus_data_t old_val,
                                            input bus_data_t new_val,
                                            input bus_sel_t  lanes);
    bus_data_t res;
    res = old_val;
    for (int i = 0; i < 4; i++)
      if (lanes[i])
        res[8*i +: 8] = new_val[8*i +: 8];
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Address decode and readback

  always_comb
  begin
    hit = 1'b1;
    case (bus.offset)
      HK_OFS_ID:      rd_word = HK_ID;
      HK_OFS_LOOP:    rd_word = bus_data_t'(loop_q);
      HK_OFS_LED:     rd_word = bus_data_t'(led_q);
      HK_OFS_EXP_DIR: rd_word = bus_data_t'(exp_dir_q);
      HK_OFS_EXP_OUT: rd_word = bus_data_t'(exp_out_q);
      HK_OFS_EXP_IN:  rd_word = bus_data_t'(exp_in_i);
      HK_OFS_DAC_A:   rd_word = bus_data_t'(dac_a_q);  // Sign extended
      HK_OFS_DAC_B:   rd_word = bus_data_t'(dac_b_q);
      HK_OFS_ADC_A:   rd_word = bus_data_t'(adc_a_i);  // Sample as of the request cycle
      HK_OFS_ADC_B:   rd_word = bus_data_t'(adc_b_i);
      default:
      begin
        rd_word = '0;
        hit     = 1'b0;
      end
    endcase
  end

  assign accept  = bus.req & ~(bus.ack | bus.err);
  assign wr_word = merge_bytes(rd_word, bus.wdata, bus.sel);

  ////////////////////////////////////////////////////////////
  // Response, one cycle after req

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end
    else
    begin
      bus.ack <= accept & hit;
      bus.err <= accept & ~hit;  // Unmapped
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (accept)
      bus.rdata <= rd_word;
  end

  ////////////////////////////////////////////////////////////
  // Writable registers

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      loop_q    <= 1'b0;
      led_q     <= '0;
      exp_dir_q <= '0;  // All pins inputs
      exp_out_q <= '0;
      dac_a_q   <= '0;
      dac_b_q   <= '0;
    end
    else if (accept && bus.we)
    begin
      case (bus.offset)
        HK_OFS_LOOP:    loop_q    <= wr_word[0];
        HK_OFS_LED:     led_q     <= wr_word[7:0];
        HK_OFS_EXP_DIR: exp_dir_q <= wr_word[7:0];
        HK_OFS_EXP_OUT: exp_out_q <= wr_word[7:0];
        HK_OFS_DAC_A:   dac_a_q   <= wr_word[13:0];
        HK_OFS_DAC_B:   dac_b_q   <= wr_word[13:0];
        default:        ;  // ID, EXP_IN, ADC and unmapped keep their value
      endcase
    end
  end

  assign loop_o    = loop_q;
  assign led_o     = led_q;
  assign exp_dir_o = exp_dir_q;
  assign exp_out_o = exp_out_q;
  assign dac_a_o   = dac_a_q;
  assign dac_b_o   = dac_b_q;

  // Every response comes from a request seen the cycle before
  a_resp_has_req: assert property (@(posedge adc_clk) disable iff (reset_i)
    (bus.ack || bus.err) |-> $past(bus.req))
    else $error("response without request");

endmodule

//--- design/sys_bus_decoder.sv
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  pitaya_pkg::bus_addr_t wb_adr_i,
  input  pitaya_pkg::bus_data_t wb_dat_i,
  input  pitaya_pkg::bus_sel_t  wb_sel_i,
  output pitaya_pkg::bus_data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  sys_bus_if.host               hk_bus
);
  import pitaya_pkg::*;

  region_t region;
  logic    wb_req;    // cyc and stb together
  logic    nul_req;   // Request into regions 1 to 7
  logic    nul_ack;

  assign region = wb_adr_i[22:20];
  assign wb_req = wb_cyc_i & wb_stb_i;

  ////////////////////////////////////////////////////////////
  // Region 0 goes to housekeeping

  assign hk_bus.req    = wb_req & (region == REGION_HK);
  assign hk_bus.we     = wb_we_i;
  assign hk_bus.offset = wb_adr_i[19:0];  // Region bits stripped
  assign hk_bus.wdata  = wb_dat_i;
  assign hk_bus.sel    = wb_sel_i;

  ////////////////////////////////////////////////////////////
  // Unused regions answer on their own

  assign nul_req = wb_req & (region != REGION_HK);

  // One ack per request, a held request is not answered twice
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      nul_ack <= 1'b0;
    else
      nul_ack <= nul_req & ~nul_ack;
  end

  ////////////////////////////////////////////////////////////
  // Response mux back to the master

  // Address held by the master through the response cycle
  assign wb_dat_o = (region == REGION_HK) ? hk_bus.rdata : '0;  // Unused slots read zero
  assign wb_ack_o = hk_bus.ack | nul_ack;
  assign wb_err_o = hk_bus.err;                                 // Only region 0 can fail

  // Exactly one kind of response at the master
  a_ack_err_excl: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(wb_ack_o && wb_err_o))
    else $error("ack and err high together");

endmodule

//--- design/sys_bus_if.sv
`timescale 1ns/1ps

// Region-0 device bus between the decoder and the housekeeping block
interface sys_bus_if;
  import pitaya_pkg::*;

  logic       req;     // Combinational, one region-0 request
  logic       we;
  hk_offset_t offset;
  bus_data_t  wdata;
  bus_sel_t   sel;

  bus_data_t  rdata;   // Registered by the device
  logic       ack;
  logic       err;     // Unmapped offset

  modport host (
    output req, we, offset, wdata, sel,
    input  rdata, ack, err
  );

  modport device (
    input  req, we, offset, wdata, sel,
    output rdata, ack, err
  );

endinterface

//--- design/pitaya_pkg.sv
package pitaya_pkg;

  ////////////////////////////////////////////////////////////
  // Bus types

  typedef logic [31:0] bus_addr_t;   // Wishbone byte address
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_sel_t;
  typedef logic [2:0]  region_t;     // Address bits 22 to 20
  typedef logic [19:0] hk_offset_t;  // Byte offset inside one region

  ////////////////////////////////////////////////////////////
  // Board data types

  typedef logic [15:0]        adc_raw_t;   // Low two bits unused by the 14 bit converter
  typedef logic signed [13:0] sample_t;    // Two's complement
  typedef logic [13:0]        dac_code_t;  // Offset form, inverted slope
  typedef logic [7:0]         exp_bank_t;
  typedef logic [7:0]         led_t;

  localparam region_t REGION_HK      = 3'd0;
  localparam int      ADC_LSB_UNUSED = 2;

  // Raw converter code that reads back as a zero sample
  localparam logic [13:0] CODE_ZERO = 14'h1fff;

  // Identification word, ASCII "RPHK"
  localparam bus_data_t HK_ID = 32'h5250_484b;

  ////////////////////////////////////////////////////////////
  // Housekeeping register map

  localparam hk_offset_t HK_OFS_ID      = 20'h00;
  localparam hk_offset_t HK_OFS_LOOP    = 20'h04;  // Bit 0 only
  localparam hk_offset_t HK_OFS_LED     = 20'h08;
  localparam hk_offset_t HK_OFS_EXP_DIR = 20'h0c;  // 1 drives the pin
  localparam hk_offset_t HK_OFS_EXP_OUT = 20'h10;
  localparam hk_offset_t HK_OFS_EXP_IN  = 20'h14;  // Read only
  localparam hk_offset_t HK_OFS_DAC_A   = 20'h18;
  localparam hk_offset_t HK_OFS_DAC_B   = 20'h1c;
  localparam hk_offset_t HK_OFS_ADC_A   = 20'h20;  // Read only
  localparam hk_offset_t HK_OFS_ADC_B   = 20'h24;  // Read only

  // Sign bit kept, lower 13 bits inverted
  // Same rule in both directions, offset code <-> two's complement
  function automatic logic [13:0] flip_low_bits(input logic [13:0] val);
    return {val[13], ~val[12:0]};
  endfunction

endpackage
